// ==== build.f ====
+incdir+testbench
hdl/looper_pkg.sv
hdl/apb_host_port.sv
hdl/phys_reg_file.sv
hdl/operand_stage.sv
hdl/alu_unit.sv
hdl/mult_unit.sv
hdl/exec_cluster_top.sv
testbench/tb_exec_cluster.sv

// ==== hdl/alu_unit.sv ====
`timescale 1ns/1ps

module alu_unit (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  ex_vld,
	input  looper_pkg::data_t     ex_op1,
	input  looper_pkg::data_t     ex_op2,
	input  looper_pkg::preg_t     ex_dst,
	input  looper_pkg::alu_mode_t ex_mode,
	output logic                  wb_vld,
	output looper_pkg::preg_t     wb_dst,
	output looper_pkg::data_t     wb_data
);
	import looper_pkg::*;

	data_t result;

	// results wrap at data width
	always_comb begin
		result = '0;
		case (ex_mode)
			ALU_ADD: result = ex_op1 + ex_op2;
			ALU_SUB: result = ex_op1 - ex_op2;
			ALU_AND: result = ex_op1 & ex_op2;
			ALU_OR:  result = ex_op1 | ex_op2;
			ALU_XOR: result = ex_op1 ^ ex_op2;
			ALU_SHL: result = ex_op1 << ex_op2[3:0];
			ALU_SHR: result = ex_op1 >> ex_op2[3:0];
			ALU_LDI: result = ex_op2;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			wb_vld <= 1'b0;
		else
			wb_vld <= ex_vld;
	end

	always_ff @(posedge clk) begin
		if (ex_vld) begin
			wb_dst  <= ex_dst;
			wb_data <= result;
		end
	end

endmodule

// ==== hdl/apb_host_port.sv ====
`timescale 1ns/1ps

module apb_host_port (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  psel,
	input  logic                  penable,
	input  logic                  pwrite,
	input  looper_pkg::paddr_t    paddr,
	input  looper_pkg::pdata_t    pwdata,
	input  looper_pkg::data_t     host_rd_data,
	input  logic                  alu1_wb_vld,
	input  logic                  alu2_wb_vld,
	input  logic                  mult_busy,
	input  logic                  opnd_busy,
	output looper_pkg::pdata_t    prdata,
	output logic                  pready,
	output logic                  pslverr,
	output logic                  host_wr_en,
	output looper_pkg::preg_t     host_wr_addr,
	output looper_pkg::data_t     host_wr_data,
	output looper_pkg::preg_t     host_rd_addr,
	output logic                  alu1_iss_vld,
	output looper_pkg::preg_t     alu1_iss_dst,
	output looper_pkg::preg_t     alu1_iss_src1,
	output looper_pkg::preg_t     alu1_iss_src2,
	output looper_pkg::alu_mode_t alu1_iss_mode,
	output logic                  alu1_iss_use_imm,
	output looper_pkg::imm_t      alu1_iss_imm,
	output logic                  alu2_iss_vld,
	output looper_pkg::preg_t     alu2_iss_dst,
	output looper_pkg::preg_t     alu2_iss_src1,
	output looper_pkg::preg_t     alu2_iss_src2,
	output looper_pkg::alu_mode_t alu2_iss_mode,
	output logic                  alu2_iss_use_imm,
	output looper_pkg::imm_t      alu2_iss_imm,
	output logic                  mult_iss_vld,
	output looper_pkg::preg_t     mult_iss_dst,
	output looper_pkg::preg_t     mult_iss_src1,
	output looper_pkg::preg_t     mult_iss_src2,
	output logic                  mult_iss_use_imm,
	output looper_pkg::imm_t      mult_iss_imm
);
	import looper_pkg::*;

	logic       access;
	logic       wr_access;
	logic       reg_hit;
	logic       status_hit;
	logic [2:0] iss_hit;
	logic [2:0] iss_vld;
	pdata_t     iss_word [3];
	logic       busy;

	assign access     = psel && penable;
	assign wr_access  = access && pwrite;
	assign reg_hit    = (paddr <= REGFILE_TOP);
	assign status_hit = (paddr == ADDR_STATUS);
	// index 0 alu1, 1 alu2, 2 mult
	assign iss_hit[0] = (paddr == ADDR_ISSUE_ALU1);
	assign iss_hit[1] = (paddr == ADDR_ISSUE_ALU2);
	assign iss_hit[2] = (paddr == ADDR_ISSUE_MULT);

	assign pready  = 1'b1;
	assign pslverr = access && !(reg_hit || status_hit || (|iss_hit));

	assign host_rd_addr = paddr[PREG_W+1:2];
	assign host_wr_addr = paddr[PREG_W+1:2];
	assign host_wr_data = pwdata[DATA_W-1:0];
	assign host_wr_en   = wr_access && reg_hit;

	assign busy = (|iss_vld) || opnd_busy || alu1_wb_vld || alu2_wb_vld || mult_busy;

	// issue addresses read back as zero
	always_comb begin
		prdata = '0;
		if (reg_hit)
			prdata = pdata_t'(host_rd_data);
		else if (status_hit)
			prdata[0] = busy;
	end

	// one-shot valids
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			iss_vld <= '0;
		else
			iss_vld <= wr_access ? iss_hit : 3'b000;
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < 3; i++) begin
			if (wr_access && iss_hit[i])
				iss_word[i] <= pwdata;
		end
	end

	assign alu1_iss_vld     = iss_vld[0];
	assign alu1_iss_dst     = iss_word[0][ISS_DST_LSB +: PREG_W];
	assign alu1_iss_src1    = iss_word[0][ISS_SRC1_LSB +: PREG_W];
	assign alu1_iss_src2    = iss_word[0][ISS_SRC2_LSB +: PREG_W];
	assign alu1_iss_mode    = alu_mode_t'(iss_word[0][ISS_MODE_LSB +: $bits(alu_mode_t)]);
	assign alu1_iss_use_imm = iss_word[0][ISS_USE_IMM_BIT];
	assign alu1_iss_imm     = iss_word[0][ISS_IMM_LSB +: IMM_W];

	assign alu2_iss_vld     = iss_vld[1];
	assign alu2_iss_dst     = iss_word[1][ISS_DST_LSB +: PREG_W];
	assign alu2_iss_src1    = iss_word[1][ISS_SRC1_LSB +: PREG_W];
	assign alu2_iss_src2    = iss_word[1][ISS_SRC2_LSB +: PREG_W];
	assign alu2_iss_mode    = alu_mode_t'(iss_word[1][ISS_MODE_LSB +: $bits(alu_mode_t)]);
	assign alu2_iss_use_imm = iss_word[1][ISS_USE_IMM_BIT];
	assign alu2_iss_imm     = iss_word[1][ISS_IMM_LSB +: IMM_W];

	// mode field ignored for mult
	assign mult_iss_vld     = iss_vld[2];
	assign mult_iss_dst     = iss_word[2][ISS_DST_LSB +: PREG_W];
	assign mult_iss_src1    = iss_word[2][ISS_SRC1_LSB +: PREG_W];
	assign mult_iss_src2    = iss_word[2][ISS_SRC2_LSB +: PREG_W];
	assign mult_iss_use_imm = iss_word[2][ISS_USE_IMM_BIT];
	assign mult_iss_imm     = iss_word[2][ISS_IMM_LSB +: IMM_W];

	// access phase always preceded by a setup phase
	assert property (@(posedge clk) disable iff (!arst_n)
		penable |-> psel && $past(psel) && !$past(penable));

endmodule

// ==== hdl/exec_cluster_top.sv ====
`timescale 1ns/1ps

module exec_cluster_top #(
	parameter int MULT_STAGES = 3
) (
	input  logic               clk,
	input  logic               arst_n,
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  looper_pkg::paddr_t paddr,
	input  looper_pkg::pdata_t pwdata,
	output looper_pkg::pdata_t prdata,
	output logic               pready,
	output logic               pslverr
);
	import looper_pkg::*;

	// host side of the register file
	logic      host_wr_en;
	preg_t     host_wr_addr;
	data_t     host_wr_data;
	preg_t     host_rd_addr;
	data_t     host_rd_data;

	// issue channels
	logic      alu1_iss_vld, alu1_iss_use_imm;
	preg_t     alu1_iss_dst, alu1_iss_src1, alu1_iss_src2;
	alu_mode_t alu1_iss_mode;
	imm_t      alu1_iss_imm;
	logic      alu2_iss_vld, alu2_iss_use_imm;
	preg_t     alu2_iss_dst, alu2_iss_src1, alu2_iss_src2;
	alu_mode_t alu2_iss_mode;
	imm_t      alu2_iss_imm;
	logic      mult_iss_vld, mult_iss_use_imm;
	preg_t     mult_iss_dst, mult_iss_src1, mult_iss_src2;
	imm_t      mult_iss_imm;

	// operand reads
	preg_t     rd_addr_0, rd_addr_1, rd_addr_2, rd_addr_3, rd_addr_4, rd_addr_5;
	data_t     rd_data_0, rd_data_1, rd_data_2, rd_data_3, rd_data_4, rd_data_5;

	// toward the units
	logic      alu1_ex_vld, alu2_ex_vld, mult_ex_vld;
	data_t     alu1_ex_op1, alu1_ex_op2, alu2_ex_op1, alu2_ex_op2;
	data_t     mult_ex_op1, mult_ex_op2;
	preg_t     alu1_ex_dst, alu2_ex_dst, mult_ex_dst;
	alu_mode_t alu1_ex_mode, alu2_ex_mode;

	// writeback
	logic      alu1_wb_vld, alu2_wb_vld, mult_wb_vld;
	preg_t     alu1_wb_dst, alu2_wb_dst, mult_wb_dst;
	data_t     alu1_wb_data, alu2_wb_data, mult_wb_data;
	logic      mult_busy;
	logic      opnd_busy;

	assign opnd_busy = alu1_ex_vld || alu2_ex_vld || mult_ex_vld;

	apb_host_port apb_u (.*);

	phys_reg_file prf_u (.*);

	operand_stage opnd_u (.*);

	alu_unit alu1_u (
		.clk     (clk),
		.arst_n  (arst_n),
		.ex_vld  (alu1_ex_vld),
		.ex_op1  (alu1_ex_op1),
		.ex_op2  (alu1_ex_op2),
		.ex_dst  (alu1_ex_dst),
		.ex_mode (alu1_ex_mode),
		.wb_vld  (alu1_wb_vld),
		.wb_dst  (alu1_wb_dst),
		.wb_data (alu1_wb_data)
	);

	alu_unit alu2_u (
		.clk     (clk),
		.arst_n  (arst_n),
		.ex_vld  (alu2_ex_vld),
		.ex_op1  (alu2_ex_op1),
		.ex_op2  (alu2_ex_op2),
		.ex_dst  (alu2_ex_dst),
		.ex_mode (alu2_ex_mode),
		.wb_vld  (alu2_wb_vld),
		.wb_dst  (alu2_wb_dst),
		.wb_data (alu2_wb_data)
	);

	mult_unit #(
		.MULT_STAGES (MULT_STAGES)
	) mult_u (
		.clk     (clk),
		.arst_n  (arst_n),
		.ex_vld  (mult_ex_vld),
		.ex_op1  (mult_ex_op1),
		.ex_op2  (mult_ex_op2),
		.ex_dst  (mult_ex_dst),
		.wb_vld  (mult_wb_vld),
		.wb_dst  (mult_wb_dst),
		.wb_data (mult_wb_data),
		.busy    (mult_busy)
	);

endmodule

// ==== hdl/looper_pkg.sv ====
package looper_pkg;

	// datapath widths
	localparam int DATA_W    = 16;
	localparam int PREG_W    = 6;
	localparam int NUM_PREGS = 64;
	localparam int IMM_W     = 10;

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [PREG_W-1:0] preg_t;
	typedef logic [IMM_W-1:0]  imm_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SHL,
		ALU_SHR,
		ALU_LDI
	} alu_mode_t;

	// apb side
	typedef logic [11:0] paddr_t;
	typedef logic [31:0] pdata_t;

	localparam paddr_t ADDR_ISSUE_ALU1 = 12'h100;
	localparam paddr_t ADDR_ISSUE_ALU2 = 12'h104;
	localparam paddr_t ADDR_ISSUE_MULT = 12'h108;
	localparam paddr_t ADDR_STATUS     = 12'h110;
	// register space starts at 12'h000, one word per entry
	localparam paddr_t REGFILE_TOP     = 12'h0FC;

	// issue word layout
	localparam int ISS_DST_LSB     = 0;
	localparam int ISS_SRC1_LSB    = 6;
	localparam int ISS_SRC2_LSB    = 12;
	localparam int ISS_MODE_LSB    = 18;
	localparam int ISS_USE_IMM_BIT = 21;
	localparam int ISS_IMM_LSB     = 22;

endpackage

// ==== hdl/mult_unit.sv ====
`timescale 1ns/1ps

module mult_unit #(
	parameter int MULT_STAGES = 3
) (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              ex_vld,
	input  looper_pkg::data_t ex_op1,
	input  looper_pkg::data_t ex_op2,
	input  looper_pkg::preg_t ex_dst,
	output logic              wb_vld,
	output looper_pkg::preg_t wb_dst,
	output looper_pkg::data_t wb_data,
	output logic              busy
);
	import looper_pkg::*;

	logic [MULT_STAGES-1:0] vld_q;
	data_t                  prod_q [MULT_STAGES];
	preg_t                  dst_q  [MULT_STAGES];
	data_t                  prod;

	// low half of the product only
	assign prod = ex_op1 * ex_op2;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			vld_q <= '0;
		end else begin
			vld_q[0] <= ex_vld;
			for (int s = 1; s < MULT_STAGES; s++)
				vld_q[s] <= vld_q[s-1];
		end
	end

	always_ff @(posedge clk) begin
		prod_q[0] <= prod;
		dst_q[0]  <= ex_dst;
		for (int s = 1; s < MULT_STAGES; s++) begin
			prod_q[s] <= prod_q[s-1];
			dst_q[s]  <= dst_q[s-1];
		end
	end

	assign wb_vld  = vld_q[MULT_STAGES-1];
	assign wb_dst  = dst_q[MULT_STAGES-1];
	assign wb_data = prod_q[MULT_STAGES-1];
	assign busy    = |vld_q;

	assert property (@(posedge clk) disable iff (!arst_n)
		ex_vld |-> ##MULT_STAGES wb_vld);

endmodule

// ==== hdl/operand_stage.sv ====
`timescale 1ns/1ps

module operand_stage (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  alu1_iss_vld,
	input  looper_pkg::preg_t     alu1_iss_dst,
	input  looper_pkg::preg_t     alu1_iss_src1,
	input  looper_pkg::preg_t     alu1_iss_src2,
	input  looper_pkg::alu_mode_t alu1_iss_mode,
	input  logic                  alu1_iss_use_imm,
	input  looper_pkg::imm_t      alu1_iss_imm,
	input  logic                  alu2_iss_vld,
	input  looper_pkg::preg_t     alu2_iss_dst,
	input  looper_pkg::preg_t     alu2_iss_src1,
	input  looper_pkg::preg_t     alu2_iss_src2,
	input  looper_pkg::alu_mode_t alu2_iss_mode,
	input  logic                  alu2_iss_use_imm,
	input  looper_pkg::imm_t      alu2_iss_imm,
	input  logic                  mult_iss_vld,
	input  looper_pkg::preg_t     mult_iss_dst,
	input  looper_pkg::preg_t     mult_iss_src1,
	input  looper_pkg::preg_t     mult_iss_src2,
	input  logic                  mult_iss_use_imm,
	input  looper_pkg::imm_t      mult_iss_imm,
	output looper_pkg::preg_t     rd_addr_0,
	output looper_pkg::preg_t     rd_addr_1,
	output looper_pkg::preg_t     rd_addr_2,
	output looper_pkg::preg_t     rd_addr_3,
	output looper_pkg::preg_t     rd_addr_4,
	output looper_pkg::preg_t     rd_addr_5,
	input  looper_pkg::data_t     rd_data_0,
	input  looper_pkg::data_t     rd_data_1,
	input  looper_pkg::data_t     rd_data_2,
	input  looper_pkg::data_t     rd_data_3,
	input  looper_pkg::data_t     rd_data_4,
	input  looper_pkg::data_t     rd_data_5,
	output logic                  alu1_ex_vld,
	output looper_pkg::data_t     alu1_ex_op1,
	output looper_pkg::data_t     alu1_ex_op2,
	output looper_pkg::preg_t     alu1_ex_dst,
	output looper_pkg::alu_mode_t alu1_ex_mode,
	output logic                  alu2_ex_vld,
	output looper_pkg::data_t     alu2_ex_op1,
	output looper_pkg::data_t     alu2_ex_op2,
	output looper_pkg::preg_t     alu2_ex_dst,
	output looper_pkg::alu_mode_t alu2_ex_mode,
	output logic                  mult_ex_vld,
	output looper_pkg::data_t     mult_ex_op1,
	output looper_pkg::data_t     mult_ex_op2,
	output looper_pkg::preg_t     mult_ex_dst
);
	import looper_pkg::*;

	// immediate is zero-extended
	function automatic data_t sel_op2(input logic use_imm, input imm_t imm, input data_t rd);
		return use_imm ? {{(DATA_W - IMM_W){1'b0}}, imm} : rd;
	endfunction

	// port pairs: alu1 0/1, alu2 2/3, mult 4/5
	assign rd_addr_0 = alu1_iss_src1;
	assign rd_addr_1 = alu1_iss_src2;
	assign rd_addr_2 = alu2_iss_src1;
	assign rd_addr_3 = alu2_iss_src2;
	assign rd_addr_4 = mult_iss_src1;
	assign rd_addr_5 = mult_iss_src2;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			alu1_ex_vld <= 1'b0;
			alu2_ex_vld <= 1'b0;
			mult_ex_vld <= 1'b0;
		end else begin
			alu1_ex_vld <= alu1_iss_vld;
			alu2_ex_vld <= alu2_iss_vld;
			mult_ex_vld <= mult_iss_vld;
		end
	end

	always_ff @(posedge clk) begin
		if (alu1_iss_vld) begin
			alu1_ex_op1  <= rd_data_0;
			alu1_ex_op2  <= sel_op2(alu1_iss_use_imm, alu1_iss_imm, rd_data_1);
			alu1_ex_dst  <= alu1_iss_dst;
			alu1_ex_mode <= alu1_iss_mode;
		end
		if (alu2_iss_vld) begin
			alu2_ex_op1  <= rd_data_2;
			alu2_ex_op2  <= sel_op2(alu2_iss_use_imm, alu2_iss_imm, rd_data_3);
			alu2_ex_dst  <= alu2_iss_dst;
			alu2_ex_mode <= alu2_iss_mode;
		end
		if (mult_iss_vld) begin
			mult_ex_op1 <= rd_data_4;
			mult_ex_op2 <= sel_op2(mult_iss_use_imm, mult_iss_imm, rd_data_5);
			mult_ex_dst <= mult_iss_dst;
		end
	end

endmodule

// ==== hdl/phys_reg_file.sv ====
`timescale 1ns/1ps

module phys_reg_file (
	input  logic              clk,
	input  logic              arst_n,
	input  looper_pkg::preg_t rd_addr_0,
	input  looper_pkg::preg_t rd_addr_1,
	input  looper_pkg::preg_t rd_addr_2,
	input  looper_pkg::preg_t rd_addr_3,
	input  looper_pkg::preg_t rd_addr_4,
	input  looper_pkg::preg_t rd_addr_5,
	output looper_pkg::data_t rd_data_0,
	output looper_pkg::data_t rd_data_1,
	output looper_pkg::data_t rd_data_2,
	output looper_pkg::data_t rd_data_3,
	output looper_pkg::data_t rd_data_4,
	output looper_pkg::data_t rd_data_5,
	input  logic              alu1_wb_vld,
	input  looper_pkg::preg_t alu1_wb_dst,
	input  looper_pkg::data_t alu1_wb_data,
	input  logic              alu2_wb_vld,
	input  looper_pkg::preg_t alu2_wb_dst,
	input  looper_pkg::data_t alu2_wb_data,
	input  logic              mult_wb_vld,
	input  looper_pkg::preg_t mult_wb_dst,
	input  looper_pkg::data_t mult_wb_data,
	input  logic              host_wr_en,
	input  looper_pkg::preg_t host_wr_addr,
	input  looper_pkg::data_t host_wr_data,
	input  looper_pkg::preg_t host_rd_addr,
	output looper_pkg::data_t host_rd_data
);
	import looper_pkg::*;

	data_t regs [NUM_PREGS];

	assign rd_data_0    = regs[rd_addr_0];
	assign rd_data_1    = regs[rd_addr_1];
	assign rd_data_2    = regs[rd_addr_2];
	assign rd_data_3    = regs[rd_addr_3];
	assign rd_data_4    = regs[rd_addr_4];
	assign rd_data_5    = regs[rd_addr_5];
	assign host_rd_data = regs[host_rd_addr];

	// later write wins: mult over alu2 over alu1 over host
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < NUM_PREGS; i++)
				regs[i] <= '0;
		end else begin
			if (host_wr_en)
				regs[host_wr_addr] <= host_wr_data;
			if (alu1_wb_vld)
				regs[alu1_wb_dst] <= alu1_wb_data;
			if (alu2_wb_vld)
				regs[alu2_wb_dst] <= alu2_wb_data;
			if (mult_wb_vld)
				regs[mult_wb_dst] <= mult_wb_data;
		end
	end

	// units never target the same entry together
	assert property (@(posedge clk) disable iff (!arst_n)
		!(alu1_wb_vld && alu2_wb_vld && alu1_wb_dst == alu2_wb_dst) &&
		!(alu1_wb_vld && mult_wb_vld && alu1_wb_dst == mult_wb_dst) &&
		!(alu2_wb_vld && mult_wb_vld && alu2_wb_dst == mult_wb_dst));

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the testbench with Verilator, then check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --timescale 1ns/1ps -f build.f \
	--top-module tb_exec_cluster -Mdir obj_dir -o tb_exec_cluster \
	&& ./obj_dir/tb_exec_cluster > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "SIMULATION PASSED" sim.log && exit 0 || exit 1

// ==== testbench/tb_tasks.svh ====
`ifndef TB_TASKS_SVH
`define TB_TASKS_SVH

// one transfer, entered 1 ns after a rising edge, left at the same point
task automatic apb_xfer(input logic wr, input paddr_t addr, input pdata_t wdata,
		output pdata_t rdata, output logic err);
	psel    = 1'b1;
	penable = 1'b0;
	pwrite  = wr;
	paddr   = addr;
	pwdata  = wdata;
	@(posedge clk);
	#1;
	penable = 1'b1;
	// access phase, outputs settled
	@(negedge clk);
	rdata = prdata;
	err   = pslverr;
	check_flag("pready in access phase", pready, 1'b1);
	@(posedge clk);
	#1;
	psel    = 1'b0;
	penable = 1'b0;
endtask

task automatic check_data(input string what, input data_t got, input data_t exp);
	check_count++;
	if (got !== exp) begin
		error_count++;
		$display("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
	end
endtask

task automatic check_flag(input string what, input logic got, input logic exp);
	check_count++;
	if (got !== exp) begin
		error_count++;
		$display("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
	end
endtask

task automatic check_err(input string what, input logic got, input logic exp);
	check_count++;
	if (got !== exp) begin
		error_count++;
		$display("Mismatch at %0t: pslverr on %s got %b expected %b", $time, what, got, exp);
	end
endtask

// expected alu result, wrapped to 16 bits
function automatic data_t model_alu(input alu_mode_t mode, input data_t a, input data_t b);
	logic [31:0] wide;
	case (mode)
		ALU_ADD: wide = {16'h0, a} + {16'h0, b};
		ALU_SUB: wide = {16'h0, a} - {16'h0, b};
		ALU_AND: wide = {16'h0, a & b};
		ALU_OR:  wide = {16'h0, a | b};
		ALU_XOR: wide = {16'h0, a ^ b};
		ALU_SHL: wide = {16'h0, a} << b[3:0];
		ALU_SHR: wide = {16'h0, a} >> b[3:0];
		default: wide = {16'h0, b};
	endcase
	return wide[15:0];
endfunction

function automatic data_t model_mul(input data_t a, input data_t b);
	logic [31:0] wide;
	wide = {16'h0, a} * {16'h0, b};
	return wide[15:0];
endfunction

task automatic reg_write(input preg_t idx, input data_t val);
	pdata_t rd;
	logic   err;
	apb_xfer(1'b1, paddr_t'({idx, 2'b00}), pdata_t'(val), rd, err);
	check_err("register write", err, 1'b0);
endtask

task automatic reg_read(input preg_t idx, output data_t val);
	pdata_t rd;
	logic   err;
	apb_xfer(1'b0, paddr_t'({idx, 2'b00}), '0, rd, err);
	check_err("register read", err, 1'b0);
	check_data("upper bits of register read", rd[31:16], '0);
	val = rd[15:0];
endtask

task automatic issue(input paddr_t unit, input preg_t dst, input preg_t src1,
		input preg_t src2, input alu_mode_t mode, input logic use_imm, input imm_t imm);
	pdata_t word;
	pdata_t rd;
	logic   err;
	word = {imm, use_imm, mode, src2, src1, dst};
	apb_xfer(1'b1, unit, word, rd, err);
	check_err("issue write", err, 1'b0);
endtask

// poll status until busy drops, report busy at the first poll
task automatic wait_idle(output logic first_busy);
	pdata_t st;
	logic   err;
	logic   first;
	first = 1'b1;
	do begin
		apb_xfer(1'b0, ADDR_STATUS, '0, st, err);
		check_err("status read", err, 1'b0);
		if (first)
			first_busy = st[0];
		first = 1'b0;
	end while (st[0]);
endtask

task automatic report_test(input string name, input int start_errors);
	tests_run++;
	$display("test %s done, %0d errors", name, error_count - start_errors);
endtask

// preload two sources, issue one instruction, compare the destination
task automatic run_op(input paddr_t unit, input alu_mode_t mode, input logic use_imm,
		input imm_t imm, input data_t a, input data_t b, input data_t exp, input string what);
	preg_t src1;
	preg_t src2;
	preg_t dst;
	data_t got;
	logic  first_busy;
	src1 = preg_t'($random(seed));
	src2 = src1 + 6'd1;
	dst  = src1 + 6'd2;
	reg_write(src1, a);
	reg_write(src2, b);
	issue(unit, dst, src1, src2, mode, use_imm, imm);
	wait_idle(first_busy);
	check_flag($sformatf("%s busy at first poll", what), first_busy, 1'b1);
	reg_read(dst, got);
	check_data(what, got, exp);
endtask

task automatic test_reset();
	int    start;
	data_t val;
	logic  busy0;
	start = error_count;
	wait_idle(busy0);
	check_flag("busy after reset", busy0, 1'b0);
	for (int i = 0; i < NUM_PREGS; i++) begin
		reg_read(preg_t'(i), val);
		check_data($sformatf("r%0d after reset", i), val, '0);
	end
	report_test("reset", start);
endtask

task automatic test_regs();
	int     start;
	data_t  shadow [NUM_PREGS];
	data_t  val;
	pdata_t rd;
	logic   err;
	start = error_count;
	for (int i = 0; i < NUM_PREGS; i++) begin
		shadow[i] = data_t'($random(seed));
		reg_write(preg_t'(i), shadow[i]);
	end
	for (int i = 0; i < NUM_PREGS; i++) begin
		reg_read(preg_t'(i), val);
		check_data($sformatf("r%0d readback", i), val, shadow[i]);
	end
	apb_xfer(1'b1, 12'h200, 32'hFFFF_FFFF, rd, err);
	check_err("write to unmapped address", err, 1'b1);
	apb_xfer(1'b0, 12'h200, '0, rd, err);
	check_err("read of unmapped address", err, 1'b1);
	apb_xfer(1'b0, ADDR_ISSUE_ALU2, '0, rd, err);
	check_flag("issue address reads nonzero", |rd, 1'b0);
	// the refused write must leave every entry alone
	for (int i = 0; i < NUM_PREGS; i++) begin
		reg_read(preg_t'(i), val);
		check_data($sformatf("r%0d after unmapped write", i), val, shadow[i]);
	end
	report_test("register access", start);
endtask

task automatic test_alu();
	int        start;
	alu_mode_t mode;
	paddr_t    unit;
	data_t     a;
	data_t     b;
	start = error_count;
	for (int u = 0; u < 2; u++) begin
		unit = (u == 0) ? ADDR_ISSUE_ALU1 : ADDR_ISSUE_ALU2;
		for (int m = int'(ALU_ADD); m <= int'(ALU_SHR); m++) begin
			mode = alu_mode_t'(m);
			a    = data_t'($random(seed));
			b    = data_t'($random(seed));
			run_op(unit, mode, 1'b0, '0, a, b, model_alu(mode, a, b),
				$sformatf("alu%0d %s", u + 1, mode.name()));
		end
	end
	report_test("alu ops", start);
endtask

task automatic test_imm();
	int        start;
	alu_mode_t mode;
	imm_t      imm;
	data_t     a;
	data_t     b;
	start = error_count;
	for (int m = 0; m < 8; m++) begin
		mode = alu_mode_t'(m);
		imm  = imm_t'($random(seed));
		a    = data_t'($random(seed));
		b    = data_t'($random(seed));
		run_op(ADDR_ISSUE_ALU1, mode, 1'b1, imm, a, b, model_alu(mode, a, data_t'(imm)),
			$sformatf("alu1 %s with immediate", mode.name()));
	end
	imm = imm_t'($random(seed));
	run_op(ADDR_ISSUE_ALU2, ALU_LDI, 1'b1, imm, '0, 16'hFFFF, data_t'(imm),
		"alu2 ALU_LDI with immediate");
	report_test("immediate", start);
endtask

task automatic test_mult();
	int    start;
	data_t a;
	data_t b;
	start = error_count;
	for (int i = 0; i < 8; i++) begin
		a = data_t'($random(seed));
		b = data_t'($random(seed));
		run_op(ADDR_ISSUE_MULT, ALU_ADD, 1'b0, '0, a, b, model_mul(a, b),
			$sformatf("mult product %0d", i));
	end
	report_test("multiplier", start);
endtask

task automatic test_back_to_back();
	int    start;
	data_t src [6];
	data_t got;
	logic  first_busy;
	start = error_count;
	// sources in r0..r5, results in r8..r10
	for (int i = 0; i < 6; i++) begin
		src[i] = data_t'($random(seed));
		reg_write(preg_t'(i), src[i]);
	end
	issue(ADDR_ISSUE_MULT, 6'd8, 6'd0, 6'd1, ALU_ADD, 1'b0, '0);
	issue(ADDR_ISSUE_ALU1, 6'd9, 6'd2, 6'd3, ALU_ADD, 1'b0, '0);
	issue(ADDR_ISSUE_ALU2, 6'd10, 6'd4, 6'd5, ALU_XOR, 1'b0, '0);
	wait_idle(first_busy);
	check_flag("busy at first poll", first_busy, 1'b1);
	reg_read(6'd8, got);
	check_data("back-to-back mult", got, model_mul(src[0], src[1]));
	reg_read(6'd9, got);
	check_data("back-to-back alu1", got, model_alu(ALU_ADD, src[2], src[3]));
	reg_read(6'd10, got);
	check_data("back-to-back alu2", got, model_alu(ALU_XOR, src[4], src[5]));
	report_test("back-to-back", start);
endtask

`endif

// ==== testbench/tb_exec_cluster.sv ====
`timescale 1ns/1ps

module tb_exec_cluster;
	import looper_pkg::*;

	// tests, worst-case apb transfers per test, cycles per transfer, margin
	localparam int NUM_TESTS       = 6;
	localparam int XFERS_PER_TEST  = 600;
	localparam int CYCLES_PER_XFER = 3;
	localparam int TIMEOUT_CYCLES  = NUM_TESTS * XFERS_PER_TEST * CYCLES_PER_XFER + 9200;

	logic   clk = 1'b0;
	logic   arst_n;
	logic   psel;
	logic   penable;
	logic   pwrite;
	paddr_t paddr;
	pdata_t pwdata;
	pdata_t prdata;
	logic   pready;
	logic   pslverr;

	int seed        = 32'h20dc2e0c;
	int error_count = 0;
	int check_count = 0;
	int tests_run   = 0;
	int cycle_count = 0;

	exec_cluster_top #(
		.MULT_STAGES (3)
	) dut (
		.clk     (clk),
		.arst_n  (arst_n),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.prdata  (prdata),
		.pready  (pready),
		.pslverr (pslverr)
	);

	`include "tb_tasks.svh"

	always #10 clk = ~clk;

	// hard stop if a test never sees busy fall
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: tests still running after %0d cycles", cycle_count);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	initial begin
		arst_n  = 1'b0;
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
		paddr   = '0;
		pwdata  = '0;
		repeat (3) @(posedge clk);
		#1;
		arst_n = 1'b1;

		test_reset();
		test_regs();
		test_alu();
		test_imm();
		test_mult();
		test_back_to_back();

		$display("tests run %0d, checks %0d, errors %0d", tests_run, check_count, error_count);
		if (error_count == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule
